// ==== source/wb_pkg.sv ====
package wb_pkg;

    // word addressed bus, so the two byte bits are gone
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    // one lane per byte of data
    localparam int SEL_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] wb_addr_t;
    typedef logic [DATA_W-1:0] wb_data_t;
    typedef logic [SEL_W-1:0]  wb_sel_t;

    // master to slave side of one wishbone port
    typedef struct packed {
        // cycle held from first strobe to last response
        logic     cyc;
        // one transfer offered this clock
        logic     stb;
        logic     we;
        wb_addr_t addr;
        // write data, ignored on reads
        wb_data_t data;
        // byte lanes written
        wb_sel_t  sel;
    } wb_req_t;

    // slave to master side of one wishbone port
    typedef struct packed {
        // one per accepted transfer, in issue order
        logic     ack;
        // offered strobe not taken this clock
        logic     stall;
        // transfer ended without a device
        logic     err;
        // read data, valid with ack
        wb_data_t data;
    } wb_rsp_t;

endpackage : wb_pkg

// ==== source/soc_map_pkg.sv ====
package soc_map_pkg;

    // top address bits that pick a block
    // 9 bits of a 30 bit word address leaves 8 MB per block
    localparam int BLOCK_W = 9;

    typedef logic [BLOCK_W-1:0] block_t;

    // 0x0000_0000 .. 0x007f_ffff, block ram
    localparam block_t MEM_BLOCK = block_t'(0);
    // 0x0080_0000 .. 0x00ff_ffff, simple device
    localparam block_t SMPL_BLOCK = block_t'(1);

    // simple device word offsets, low four address bits
    typedef enum logic [3:0] {
        // read only id word
        REG_ID       = 4'h0,
        // plain read/write word
        REG_SCRATCH  = 4'h1,
        // last faulting word address, read as bytes
        REG_ERR_ADDR = 4'h2,
        // clocks since reset
        REG_POWER    = 4'h3,
        // bit 0 drives the irq line
        REG_IRQ      = 4'h4
    } smpl_reg_e;

    // id word of the simple device
    localparam logic [31:0] SMPL_ID = 32'h2019_1028;

endpackage : soc_map_pkg

// ==== source/wb_priority_arbiter.sv ====
`timescale 1ns/1ns

module wb_priority_arbiter (
    input  logic            i_clk,
    input  logic            i_reset,
    // preferred master
    input  wb_pkg::wb_req_t i_a,
    output wb_pkg::wb_rsp_t o_a,
    // secondary master
    input  wb_pkg::wb_req_t i_b,
    output wb_pkg::wb_rsp_t o_b,
    // merged port toward the slave side
    output wb_pkg::wb_req_t o_m,
    input  wb_pkg::wb_rsp_t i_m
);

    // set while b owns the bus
    logic            owner_b_q;
    // request of whichever port owns the bus
    wb_pkg::wb_req_t sel_req;

    assign sel_req = owner_b_q ? i_b : i_a;

    // owner register
    // ownership only moves while the owner is idle,
    // so responses still in flight go back to the right port
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owner_b_q <= 1'b0;
        end else if (!sel_req.cyc) begin
            // a wins a tie
            if (i_a.cyc) begin
                owner_b_q <= 1'b0;
            end else if (i_b.cyc) begin
                owner_b_q <= 1'b1;
            end
        end
    end

    // merged request
    always_comb begin
        o_m = sel_req;
        // strobe only inside the owner's own cycle
        o_m.stb = sel_req.cyc && sel_req.stb;
    end

    // responses
    // data goes to both ports, handshakes only to the owner
    always_comb begin
        o_a = i_m;
        o_b = i_m;
        o_a.ack = i_m.ack && !owner_b_q;
        o_a.err = i_m.err && !owner_b_q;
        o_b.ack = i_m.ack && owner_b_q;
        o_b.err = i_m.err && owner_b_q;
        // non-owner is held off
        o_a.stall = i_m.stall || owner_b_q;
        o_b.stall = i_m.stall || !owner_b_q;
    end

    // every ack or err from below lands while the owner still holds cyc,
    // otherwise it would reach a port that no longer owns the bus
    a_rsp_inside_owner_cycle : assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_m.ack || i_m.err) |-> sel_req.cyc
    );

endmodule : wb_priority_arbiter

// ==== source/bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder (
    input  logic             i_clk,
    input  logic             i_reset,
    // merged master port
    input  wb_pkg::wb_req_t  i_m,
    output wb_pkg::wb_rsp_t  o_m,
    // device strobes
    output logic             o_mem_stb,
    output logic             o_smpl_stb,
    // device returns
    input  logic             i_mem_ack,
    input  logic             i_smpl_ack,
    input  wb_pkg::wb_data_t i_mem_data,
    input  wb_pkg::wb_data_t i_smpl_data,
    // strobe that hit no device, one clock late
    output logic             o_bus_err
);

    // block field of the word address
    soc_map_pkg::block_t block;
    logic                mem_sel;
    logic                smpl_sel;
    logic                none_sel;
    logic                ack_q;
    logic                err_q;
    wb_pkg::wb_data_t    data_q;

    assign block = i_m.addr[wb_pkg::ADDR_W-1 -: soc_map_pkg::BLOCK_W];

    // address decode
    assign mem_sel  = (block == soc_map_pkg::MEM_BLOCK);
    assign smpl_sel = (block == soc_map_pkg::SMPL_BLOCK);
    assign none_sel = !mem_sel && !smpl_sel;

    assign o_mem_stb  = i_m.stb && mem_sel;
    assign o_smpl_stb = i_m.stb && smpl_sel;

    // handshake return
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= i_mem_ack || i_smpl_ack;
            // unmapped strobe errors out on the next clock
            err_q <= i_m.stb && none_sel;
        end
    end

    // data return
    // zero when nobody acks, so idle cycles show a clean bus
    always_ff @(posedge i_clk) begin
        if (i_smpl_ack) begin
            data_q <= i_smpl_data;
        end else if (i_mem_ack) begin
            data_q <= i_mem_data;
        end else begin
            data_q <= '0;
        end
    end

    assign o_m.ack   = ack_q;
    assign o_m.err   = err_q;
    // no device here ever holds off a strobe
    assign o_m.stall = 1'b0;
    assign o_m.data  = data_q;

    assign o_bus_err = err_q;

    // selects are exclusive and devices answer in strobe order,
    // so two devices never answer on the same clock
    a_single_device_ack : assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(i_mem_ack && i_smpl_ack)
    );

endmodule : bus_decoder

// ==== source/simple_device.sv ====
`timescale 1ns/1ns

module simple_device (
    input  logic             i_clk,
    input  logic             i_reset,
    // master bus request, watched on every clock
    input  wb_pkg::wb_req_t  i_req,
    // strobe already decoded for this device
    input  logic             i_stb,
    output logic             o_ack,
    output wb_pkg::wb_data_t o_data,
    // registered bus error from the decoder
    input  logic             i_bus_err,
    output logic             o_irq
);

    soc_map_pkg::smpl_reg_e reg_sel;
    logic                   ack_q;
    logic                   irq_q;
    wb_pkg::wb_data_t       data_q;
    wb_pkg::wb_data_t       scratch_q;
    // clocks since reset
    logic [31:0]            power_q;
    // word address of the last bus error
    wb_pkg::wb_addr_t       err_addr_q;

    // register offset from the low address bits
    assign reg_sel = soc_map_pkg::smpl_reg_e'(i_req.addr[3:0]);

    // every strobe answers on the next clock
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= i_stb;
        end
    end

    // irq flag, written from bit 0
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            irq_q <= 1'b0;
        end else if (i_stb && i_req.we && (reg_sel == soc_map_pkg::REG_IRQ)) begin
            irq_q <= i_req.data[0];
        end
    end

    // scratch word, full width regardless of sel
    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we && (reg_sel == soc_map_pkg::REG_SCRATCH)) begin
            scratch_q <= i_req.data;
        end
    end

    // power counter
    // top bit sticks once set, the rest keeps wrapping
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            power_q <= '0;
        end else if (!power_q[31]) begin
            power_q <= power_q + 32'd1;
        end else begin
            power_q[30:0] <= power_q[30:0] + 31'd1;
        end
    end

    // error strobe is a clock behind the fault,
    // the faulting master still holds addr here
    always_ff @(posedge i_clk) begin
        if (i_bus_err) begin
            err_addr_q <= i_req.addr;
        end
    end

    // read mux, registered with the strobe
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (reg_sel)
                soc_map_pkg::REG_ID:       data_q <= soc_map_pkg::SMPL_ID;
                soc_map_pkg::REG_SCRATCH:  data_q <= scratch_q;
                // byte address view of the captured word
                soc_map_pkg::REG_ERR_ADDR: data_q <= {err_addr_q, 2'b00};
                soc_map_pkg::REG_POWER:    data_q <= power_q;
                soc_map_pkg::REG_IRQ:      data_q <= {31'd0, irq_q};
                default:                   data_q <= '0;
            endcase
        end
    end

    assign o_ack  = ack_q;
    assign o_data = data_q;
    assign o_irq  = irq_q;

endmodule : simple_device

// ==== source/block_ram.sv ====
`timescale 1ns/1ns

module block_ram #(
    // depth in words as a power of two
    parameter int MEM_WORDS = 1024
) (
    input  logic             i_clk,
    input  wb_pkg::wb_req_t  i_req,
    // strobe already decoded for the ram window
    input  logic             i_stb,
    output logic             o_ack,
    output wb_pkg::wb_data_t o_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    wb_pkg::wb_data_t mem [MEM_WORDS];
    // upper address bits alias onto the array
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    wb_pkg::wb_data_t data_q;

    assign idx = i_req.addr[IDX_W-1:0];

    // single port with byte lane writes and read before write
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            if (i_req.we) begin
                for (int lane = 0; lane < wb_pkg::SEL_W; lane++) begin
                    if (i_req.sel[lane]) begin
                        mem[idx][lane*8 +: 8] <= i_req.data[lane*8 +: 8];
                    end
                end
            end
            data_q <= mem[idx];
        end
    end

    // strobe delayed by one clock
    always_ff @(posedge i_clk) begin
        ack_q <= i_stb;
    end

    assign o_ack  = ack_q;
    assign o_data = data_q;

    // strobes only come in for the ram window
    a_stb_in_ram_window : assert property (
        @(posedge i_clk)
        i_stb |->
            (i_req.addr[wb_pkg::ADDR_W-1 -: soc_map_pkg::BLOCK_W] == soc_map_pkg::MEM_BLOCK)
    );

endmodule : block_ram

// ==== source/soc_interconnect.sv ====
`timescale 1ns/1ns

module soc_interconnect #(
    // block ram depth in words
    parameter int MEM_WORDS = 1024
) (
    input  logic            i_clk,
    input  logic            i_reset,
    // data fetch, highest priority
    input  wb_pkg::wb_req_t i_dfetch,
    output wb_pkg::wb_rsp_t o_dfetch,
    // instruction fetch
    input  wb_pkg::wb_req_t i_ifetch,
    output wb_pkg::wb_rsp_t o_ifetch,
    // debug master, lowest priority
    input  wb_pkg::wb_req_t i_dbg,
    output wb_pkg::wb_rsp_t o_dbg,
    output logic            o_irq
);

    // internal bus, dfetch and ifetch merged
    wb_pkg::wb_req_t  ibus_req;
    wb_pkg::wb_rsp_t  ibus_rsp;
    // master bus, internal bus and debug merged
    wb_pkg::wb_req_t  mbus_req;
    wb_pkg::wb_rsp_t  mbus_rsp;
    // device side
    logic             mem_stb;
    logic             mem_ack;
    wb_pkg::wb_data_t mem_data;
    logic             smpl_stb;
    logic             smpl_ack;
    wb_pkg::wb_data_t smpl_data;
    logic             bus_err;

    // dfetch over ifetch
    wb_priority_arbiter ibus_arb (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_a     (i_dfetch),
        .o_a     (o_dfetch),
        .i_b     (i_ifetch),
        .o_b     (o_ifetch),
        .o_m     (ibus_req),
        .i_m     (ibus_rsp)
    );

    // internal bus over debug
    wb_priority_arbiter mbus_arb (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_a     (ibus_req),
        .o_a     (ibus_rsp),
        .i_b     (i_dbg),
        .o_b     (o_dbg),
        .o_m     (mbus_req),
        .i_m     (mbus_rsp)
    );

    bus_decoder decoder_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_m         (mbus_req),
        .o_m         (mbus_rsp),
        .o_mem_stb   (mem_stb),
        .o_smpl_stb  (smpl_stb),
        .i_mem_ack   (mem_ack),
        .i_smpl_ack  (smpl_ack),
        .i_mem_data  (mem_data),
        .i_smpl_data (smpl_data),
        .o_bus_err   (bus_err)
    );

    simple_device smpl_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_req     (mbus_req),
        .i_stb     (smpl_stb),
        .o_ack     (smpl_ack),
        .o_data    (smpl_data),
        .i_bus_err (bus_err),
        .o_irq     (o_irq)
    );

    block_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) ram_i (
        .i_clk  (i_clk),
        .i_req  (mbus_req),
        .i_stb  (mem_stb),
        .o_ack  (mem_ack),
        .o_data (mem_data)
    );

endmodule : soc_interconnect

// ==== sim/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// reference copy of what the bus should hold
wb_pkg::wb_data_t ram_m [MEM_WORDS];
wb_pkg::wb_data_t scratch_m;
wb_pkg::wb_addr_t err_addr_m;
logic             irq_m;

task automatic fail_now(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
endtask

task automatic check_rsp_data(input string name, input wb_pkg::wb_data_t got,
                              input wb_pkg::wb_data_t exp);
    if (got !== exp) begin
        fail_now($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
endtask

task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_now($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
        fail_now($sformatf("ERROR o_irq got 0x%0h expected 0x%0h", got, exp));
    end
endtask

// applies one accepted transfer to the model
// and tells what its response must be
function automatic exp_t model_access(input op_t op);
    exp_t                e;
    soc_map_pkg::block_t blk;
    logic [3:0]          off;
    logic [IDX_W-1:0]    idx;
    e = '0;
    blk = op.addr[wb_pkg::ADDR_W-1 -: soc_map_pkg::BLOCK_W];
    off = op.addr[3:0];
    // ram aliases above its depth
    idx = op.addr[IDX_W-1:0];
    if (blk == soc_map_pkg::MEM_BLOCK) begin
        if (op.we) begin
            for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                if (op.sel[b]) begin
                    ram_m[idx][b*8 +: 8] = op.data[b*8 +: 8];
                end
            end
        end else begin
            e.chk = 1'b1;
            e.data = ram_m[idx];
        end
    end else if (blk == soc_map_pkg::SMPL_BLOCK) begin
        if (op.we && off == soc_map_pkg::REG_SCRATCH) begin
            scratch_m = op.data;
        end else if (op.we && off == soc_map_pkg::REG_IRQ) begin
            irq_m = op.data[0];
            e.irq_chk = 1'b1;
            e.irq = op.data[0];
        end else if (!op.we) begin
            e.chk = 1'b1;
            case (off)
                soc_map_pkg::REG_ID:       e.data = soc_map_pkg::SMPL_ID;
                soc_map_pkg::REG_SCRATCH:  e.data = scratch_m;
                soc_map_pkg::REG_ERR_ADDR: e.data = {err_addr_m, 2'b00};
                soc_map_pkg::REG_IRQ:      e.data = {31'd0, irq_m};
                // counter value only checked for growth
                soc_map_pkg::REG_POWER:    e = '{pwr: 1'b1, default: '0};
                default:                   e.data = '0;
            endcase
        end
    end else begin
        // unmapped, error and address capture
        e.err = 1'b1;
        err_addr_m = op.addr;
    end
    return e;
endfunction

`endif

// ==== sim/tb_soc.sv ====
`timescale 1ns/1ns

module tb_soc;

    localparam int MEM_WORDS = 1024;
    localparam int IDX_W = $clog2(MEM_WORDS);
    // block 0 bits above the ram depth
    localparam int HI_W = wb_pkg::ADDR_W - soc_map_pkg::BLOCK_W - IDX_W;
    localparam int N_POOL = 16;
    localparam int N_ROUNDS = 4;
    localparam int MAX_BURST = 6;
    // device, error and priority tests add fewer than 32 transfers
    localparam int N_TRANS = N_POOL + 3 * N_ROUNDS * MAX_BURST + 32;
    localparam int CYCLE_LIMIT = 2 * N_TRANS * 10;

    // one transfer as a master offers it
    typedef struct packed {
        logic             we;
        wb_pkg::wb_addr_t addr;
        wb_pkg::wb_data_t data;
        wb_pkg::wb_sel_t  sel;
    } op_t;

    // expected response of one accepted transfer
    typedef struct packed {
        logic             err;
        logic             chk;
        logic             pwr;
        logic             irq_chk;
        logic             irq;
        wb_pkg::wb_data_t data;
    } exp_t;

    logic             i_clk;
    logic             i_reset;
    logic             o_irq;
    // masters by index in the order dfetch ifetch dbg
    wb_pkg::wb_req_t  mreq [3];
    wb_pkg::wb_rsp_t  mrsp [3];
    string            port_name [3];
    logic [31:0]      lfsr;
    // ram words in use get a full write first
    logic [IDX_W-1:0] pool [N_POOL];
    int               cycle;
    int               first_rsp [3];
    int               last_rsp [3];
    wb_pkg::wb_data_t power_vals [$];
    op_t              ops_a [$];
    op_t              ops_b [$];

    `include "tb_checks.svh"

    soc_interconnect #(
        .MEM_WORDS (MEM_WORDS)
    ) dut_i (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_dfetch (mreq[0]),
        .o_dfetch (mrsp[0]),
        .i_ifetch (mreq[1]),
        .o_ifetch (mrsp[1]),
        .i_dbg    (mreq[2]),
        .o_dbg    (mrsp[2]),
        .o_irq    (o_irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= CYCLE_LIMIT);
        fail_now("timeout, the tests did not finish within the cycle limit");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic op_t ram_op(input logic we, input int slot, input logic full);
        op_t         op;
        logic [31:0] hi;
        logic [31:0] sel;
        hi = rand_bits(HI_W);
        op.we = we;
        op.addr = {soc_map_pkg::MEM_BLOCK, hi[HI_W-1:0], pool[slot]};
        op.data = rand_bits(32);
        sel = rand_bits(4);
        op.sel = full ? '1 : sel[3:0];
        return op;
    endfunction

    function automatic op_t dev_op(input logic we, input logic [3:0] off,
                                   input wb_pkg::wb_data_t data);
        op_t op;
        op = '{we: we, data: data, sel: '1, default: '0};
        op.addr[wb_pkg::ADDR_W-1 -: soc_map_pkg::BLOCK_W] = soc_map_pkg::SMPL_BLOCK;
        op.addr[3:0] = off;
        return op;
    endfunction

    // random block at 2 or above
    function automatic op_t bad_op();
        op_t         op;
        logic [31:0] blk;
        logic [31:0] low;
        blk = rand_bits(soc_map_pkg::BLOCK_W);
        low = rand_bits(21);
        if (blk[8:0] < 9'd2) begin
            blk[8:0] = blk[8:0] + 9'd2;
        end
        op = '{we: blk[0], data: low, sel: '1, default: '0};
        op.addr = {blk[8:0], low[20:0]};
        return op;
    endfunction

    function automatic wb_pkg::wb_req_t to_req(input op_t op);
        return '{cyc: 1'b1, stb: 1'b1, we: op.we, addr: op.addr, data: op.data,
                 sel: op.sel};
    endfunction

    task automatic clear_stamps();
        for (int m = 0; m < 3; m++) begin
            first_rsp[m] = -1;
            last_rsp[m] = -1;
        end
    endtask

    // one bus cycle of one master that holds cyc until every response is in
    task automatic run_master(input int m, input op_t ops[$]);
        exp_t pend [$];
        exp_t e;
        int   issued;
        int   done;
        issued = 0;
        done = 0;
        @(posedge i_clk);
        #1;
        mreq[m] = to_req(ops[0]);
        while (done < ops.size()) begin
            @(negedge i_clk);
            if (mrsp[m].ack || mrsp[m].err) begin
                if (pend.size() == 0) begin
                    fail_now($sformatf("%s answered with nothing outstanding", port_name[m]));
                end
                // in issue order
                e = pend.pop_front();
                check_err({port_name[m], ".err"}, mrsp[m].err, e.err);
                check_err({port_name[m], ".ack"}, mrsp[m].ack, !e.err);
                if (e.chk) begin
                    check_rsp_data({port_name[m], ".data"}, mrsp[m].data, e.data);
                end
                if (e.pwr) begin
                    power_vals.push_back(mrsp[m].data);
                end
                if (e.irq_chk) begin
                    check_irq(o_irq, e.irq);
                end
                if (first_rsp[m] < 0) begin
                    first_rsp[m] = cycle;
                end
                last_rsp[m] = cycle;
                done++;
            end
            // taken on the coming edge
            if (mreq[m].stb && !mrsp[m].stall) begin
                pend.push_back(model_access(ops[issued]));
                issued++;
            end
            @(posedge i_clk);
            #1;
            // addr stays put after the last strobe
            if (issued < ops.size()) begin
                mreq[m] = to_req(ops[issued]);
            end else begin
                mreq[m].stb = 1'b0;
            end
        end
        mreq[m].cyc = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        int          n;
        port_name[0] = "o_dfetch";
        port_name[1] = "o_ifetch";
        port_name[2] = "o_dbg";
        lfsr = 32'h420e_78f5;
        i_reset = 1'b1;
        irq_m = 1'b0;
        for (int m = 0; m < 3; m++) begin
            mreq[m] = '0;
        end
        clear_stamps();
        for (int s = 0; s < N_POOL; s++) begin
            r = rand_bits(IDX_W);
            pool[s] = r[IDX_W-1:0];
        end
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        // quiet bus before any strobe
        repeat (4) begin
            @(negedge i_clk);
            for (int m = 0; m < 3; m++) begin
                check_err({port_name[m], ".ack"}, mrsp[m].ack, 1'b0);
                check_err({port_name[m], ".err"}, mrsp[m].err, 1'b0);
            end
            check_irq(o_irq, 1'b0);
        end
        // power counter grows
        ops_a = '{dev_op(1'b0, soc_map_pkg::REG_POWER, '0),
                  dev_op(1'b0, soc_map_pkg::REG_POWER, '0)};
        run_master(0, ops_a);
        if (power_vals[1] <= power_vals[0]) begin
            fail_now("power counter did not increase between two reads");
        end
        // full word fill of the pool
        ops_a.delete();
        for (int s = 0; s < N_POOL; s++) begin
            ops_a.push_back(ram_op(1'b1, s, 1'b1));
        end
        run_master(0, ops_a);
        // random single and burst traffic from every master
        for (int k = 0; k < N_ROUNDS; k++) begin
            for (int m = 0; m < 3; m++) begin
                ops_a.delete();
                r = rand_bits(3);
                n = 1 + int'(r % MAX_BURST);
                for (int i = 0; i < n; i++) begin
                    r = rand_bits(5);
                    ops_a.push_back(ram_op(r[4], int'(r[3:0]), 1'b0));
                end
                run_master(m, ops_a);
            end
        end
        // simple device registers where each irq write ends its burst
        r = rand_bits(32);
        ops_a = '{dev_op(1'b0, soc_map_pkg::REG_ID, '0),
                  dev_op(1'b1, soc_map_pkg::REG_SCRATCH, r),
                  dev_op(1'b0, soc_map_pkg::REG_SCRATCH, '0),
                  dev_op(1'b1, soc_map_pkg::REG_IRQ, 32'd1)};
        run_master(2, ops_a);
        ops_a = '{dev_op(1'b0, soc_map_pkg::REG_IRQ, '0),
                  dev_op(1'b1, soc_map_pkg::REG_IRQ, 32'd0)};
        run_master(2, ops_a);
        // unmapped strobes and captured address
        for (int m = 0; m < 3; m++) begin
            ops_a = '{bad_op()};
            run_master(m, ops_a);
            // no ack trails the error
            @(negedge i_clk);
            check_err({port_name[m], ".ack"}, mrsp[m].ack, 1'b0);
            ops_a = '{dev_op(1'b0, soc_map_pkg::REG_ERR_ADDR, '0)};
            run_master(m, ops_a);
        end
        // dfetch left owning the internal bus
        ops_a = '{dev_op(1'b0, soc_map_pkg::REG_ID, '0)};
        run_master(0, ops_a);
        ops_a = '{ram_op(1'b0, 1, 1'b0), ram_op(1'b1, 2, 1'b0), ram_op(1'b0, 3, 1'b0)};
        ops_b = '{ram_op(1'b0, 4, 1'b0), ram_op(1'b0, 2, 1'b0), ram_op(1'b1, 5, 1'b0)};
        clear_stamps();
        fork
            run_master(0, ops_a);
            run_master(1, ops_b);
        join
        if (last_rsp[0] >= first_rsp[1]) begin
            fail_now("ifetch was answered before dfetch finished");
        end
        // ifetch now owns the internal bus
        ops_a = '{ram_op(1'b0, 6, 1'b0), ram_op(1'b1, 7, 1'b0)};
        ops_b = '{ram_op(1'b0, 7, 1'b0), ram_op(1'b0, 6, 1'b0)};
        clear_stamps();
        fork
            run_master(1, ops_a);
            run_master(2, ops_b);
        join
        if (last_rsp[1] >= first_rsp[2]) begin
            fail_now("dbg was answered before ifetch finished");
        end
        // ifetch holds cyc and dfetch comes in late
        ops_a = '{ram_op(1'b0, 8, 1'b0), ram_op(1'b1, 9, 1'b0),
                  ram_op(1'b0, 9, 1'b0), ram_op(1'b0, 10, 1'b0)};
        ops_b = '{ram_op(1'b1, 10, 1'b0), ram_op(1'b0, 11, 1'b0)};
        clear_stamps();
        fork
            run_master(1, ops_a);
            begin
                repeat (2) @(posedge i_clk);
                run_master(0, ops_b);
            end
        join
        if (last_rsp[1] >= first_rsp[0]) begin
            fail_now("dfetch took the bus while ifetch still held cyc");
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule : tb_soc

// ==== project.f ====
+incdir+sim
source/wb_pkg.sv
source/soc_map_pkg.sv
source/wb_priority_arbiter.sv
source/bus_decoder.sv
source/simple_device.sv
source/block_ram.sv
source/soc_interconnect.sv
sim/tb_soc.sv
